/* Bender.yml */
package:
  name: forth_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/forth_pkg.sv
      - src/data_stack.sv
      - src/word_decode.sv
      - src/word_execute.sv
      - src/result_port.sv
      - src/forth_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/forth_core_chk.sv
      - testbench/forth_core_tb.sv

/* project.f */
+incdir+src
src/forth_pkg.sv
src/data_stack.sv
src/word_decode.sv
src/word_execute.sv
src/result_port.sv
src/forth_core.sv
testbench/forth_core_chk.sv
testbench/forth_core_tb.sv

/* src/data_stack.sv */
/* stack memory below the TOS register
   pointer with push and pop, unregistered indexed read */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module data_stack import forth_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire stack_op_e                 op,     // from execute, already checked
    input  wire logic [`FORTH_DATA_W-1:0]  wdata,  // old tos on push
    input  wire logic [`FORTH_SP_W-1:0]    index,  // 0 is the memory top
    output logic      [`FORTH_DATA_W-1:0]  rdata,
    output logic      [`FORTH_SP_W-1:0]    fill    // cells in use
);

    localparam int SP_W   = `FORTH_SP_W;
    localparam int ADDR_W = $clog2(`FORTH_STACK_DEPTH);

    logic [`FORTH_DATA_W-1:0] mem [`FORTH_STACK_DEPTH];
    logic [`FORTH_SP_W-1:0]   sp;       // next free cell
    logic [`FORTH_SP_W-1:0]   rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    // unregistered read below the pointer
    assign rd_ptr  = sp - SP_W'(1) - index;
    assign rdata   = mem[rd_ptr[ADDR_W-1:0]];
    assign fill    = sp;
    assign do_push = (op == SOP_PUSH);  // execute only pushes below capacity
    assign do_pop  = (op == SOP_POP);   // and only pops a non empty memory

    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= '0;                       // empty
        end else if (do_push) begin
            sp <= sp + SP_W'(1);
        end else if (do_pop) begin
            sp <= sp - SP_W'(1);
        end
    end

    // cell storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[sp[ADDR_W-1:0]] <= wdata;   // write at the old pointer
        end
    end

endmodule : data_stack

`default_nettype wire

/* src/forth_core.sv */
/* forth_core: top level of the three stage stack core
   decode, execute and result stages */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module forth_core import forth_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      instr_valid,
    input  wire opcode_e                   opcode,
    input  wire logic [`FORTH_DATA_W-1:0]  imm,
    output logic                           emit_valid,
    output logic      [`FORTH_DATA_W-1:0]  emit_data,
    output logic      [`FORTH_SP_W-1:0]    depth,
    output logic                           underflow,
    output logic                           overflow
);

    // decode to execute
    logic                     dec_valid;
    stack_op_e                stack_op;
    alu_fn_e                  alu_fn;
    tos_src_e                 tos_src;
    logic [`FORTH_SP_W-1:0]   read_index;
    logic [`FORTH_DATA_W-1:0] dec_imm;
    logic                     emit_req;
    logic [`FORTH_SP_W-1:0]   need_depth;
    logic                     grows;

    // execute to result
    logic                     ex_valid;
    logic                     emit_fire;
    logic [`FORTH_DATA_W-1:0] emit_value;
    logic [`FORTH_SP_W-1:0]   ex_depth;
    logic                     err_under;
    logic                     err_over;

    word_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .imm         (imm),
        .dec_valid   (dec_valid),
        .stack_op    (stack_op),
        .alu_fn      (alu_fn),
        .tos_src     (tos_src),
        .read_index  (read_index),
        .dec_imm     (dec_imm),
        .emit_req    (emit_req),
        .need_depth  (need_depth),
        .grows       (grows)
    );

    word_execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .stack_op   (stack_op),
        .alu_fn     (alu_fn),
        .tos_src    (tos_src),
        .read_index (read_index),
        .dec_imm    (dec_imm),
        .emit_req   (emit_req),
        .need_depth (need_depth),
        .grows      (grows),
        .ex_valid   (ex_valid),
        .emit_fire  (emit_fire),
        .emit_value (emit_value),
        .depth      (ex_depth),
        .err_under  (err_under),
        .err_over   (err_over)
    );

    result_port u_result (
        .clk        (clk),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .emit_fire  (emit_fire),
        .emit_value (emit_value),
        .depth      (ex_depth),
        .err_under  (err_under),
        .err_over   (err_over),
        .emit_valid (emit_valid),
        .emit_data  (emit_data),
        .depth_out  (depth),
        .underflow  (underflow),
        .overflow   (overflow)
    );

endmodule : forth_core

`default_nettype wire

/* src/forth_defines.svh */
/* sizing macros for the stack core
   cell width, stack memory depth, pointer width, pipeline latency */
`ifndef FORTH_DEFINES_SVH
`define FORTH_DEFINES_SVH

// one stack cell
`define FORTH_DATA_W 32

// cells in the stack memory, TOS register not counted
`define FORTH_STACK_DEPTH 16

// pointer and depth width, one extra bit so a full stack fits
`define FORTH_SP_W ($clog2(`FORTH_STACK_DEPTH) + 1)

// strobe to result outputs, one cycle per stage
`define FORTH_LATENCY 3

`endif // FORTH_DEFINES_SVH

/* src/forth_pkg.sv */
/* shared types of the stack core
   opcodes, stack memory ops, ALU functions, TOS sources */
`default_nettype none

package forth_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LIT  = 4'd1,   // push imm
        OP_DUP  = 4'd2,
        OP_DROP = 4'd3,
        OP_OVER = 4'd4,
        OP_PICK = 4'd5,   // imm is the index
        OP_ADD  = 4'd6,
        OP_SUB  = 4'd7,   // second minus tos
        OP_AND  = 4'd8,
        OP_OR   = 4'd9,
        OP_XOR  = 4'd10,
        OP_EMIT = 4'd11   // pop and send out
    } opcode_e;

    typedef enum logic [1:0] {
        SOP_NOP  = 2'b00,
        SOP_PUSH = 2'b01,
        SOP_POP  = 2'b10
    } stack_op_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_fn_e;

    typedef enum logic [1:0] {
        TOS_KEEP = 2'd0,
        TOS_IMM  = 2'd1,
        TOS_READ = 2'd2,   // cell from the stack memory
        TOS_ALU  = 2'd3
    } tos_src_e;

endpackage : forth_pkg

`default_nettype wire

/* src/result_port.sv */
/* result_port: last pipeline stage
   emit strobe and data, depth, sticky error flags */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module result_port import forth_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      ex_valid,
    input  wire logic                      emit_fire,
    input  wire logic [`FORTH_DATA_W-1:0]  emit_value,
    input  wire logic [`FORTH_SP_W-1:0]    depth,
    input  wire logic                      err_under,
    input  wire logic                      err_over,
    output logic                           emit_valid,
    output logic      [`FORTH_DATA_W-1:0]  emit_data,
    output logic      [`FORTH_SP_W-1:0]    depth_out,
    output logic                           underflow,
    output logic                           overflow
);

    always_ff @(posedge clk) begin
        if (reset) begin
            emit_valid <= 1'b0;
            depth_out  <= '0;
            underflow  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            emit_valid <= ex_valid && emit_fire;    // single cycle
            if (ex_valid) begin
                depth_out <= depth;
            end
            if (ex_valid && err_under) begin
                underflow <= 1'b1;                  // held until reset
            end
            if (ex_valid && err_over) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit_fire) begin
            emit_data <= emit_value;                // holds the last emitted value
        end
    end

endmodule : result_port

`default_nettype wire

/* src/word_decode.sv */
/* word_decode: first pipeline stage
   opcode to stack op, ALU function, TOS source, read index and depth check */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module word_decode import forth_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      instr_valid,
    input  wire opcode_e                   opcode,
    input  wire logic [`FORTH_DATA_W-1:0]  imm,
    output logic                           dec_valid,
    output stack_op_e                      stack_op,
    output alu_fn_e                        alu_fn,
    output tos_src_e                       tos_src,
    output logic      [`FORTH_SP_W-1:0]    read_index,
    output logic      [`FORTH_DATA_W-1:0]  dec_imm,
    output logic                           emit_req,
    output logic      [`FORTH_SP_W-1:0]    need_depth,
    output logic                           grows
);

    localparam int SP_W = `FORTH_SP_W;

    stack_op_e              op_d;
    alu_fn_e                fn_d;
    tos_src_e               src_d;
    logic [`FORTH_SP_W-1:0] idx_d;
    logic [`FORTH_SP_W-1:0] need_d;
    logic                   emit_d;
    logic                   grows_d;
    logic [`FORTH_SP_W-1:0] pick_n;
    logic                   pick_far;   // index beyond any possible depth

    assign pick_n   = imm[`FORTH_SP_W-1:0];
    assign pick_far = (imm > `FORTH_DATA_W'(`FORTH_STACK_DEPTH));

    always_comb begin
        op_d    = SOP_NOP;
        fn_d    = ALU_PASS;
        src_d   = TOS_KEEP;
        idx_d   = '0;
        need_d  = '0;
        emit_d  = 1'b0;
        grows_d = 1'b0;
        case (opcode)
            OP_LIT: begin
                op_d    = SOP_PUSH;
                src_d   = TOS_IMM;
                grows_d = 1'b1;
            end
            OP_DUP: begin
                op_d    = SOP_PUSH;
                need_d  = SP_W'(1);
                grows_d = 1'b1;
            end
            OP_OVER: begin
                op_d    = SOP_PUSH;
                src_d   = TOS_READ;         // memory top
                need_d  = SP_W'(2);
                grows_d = 1'b1;
            end
            OP_PICK: begin
                op_d    = SOP_PUSH;
                grows_d = 1'b1;
                if (imm == '0) begin
                    need_d = SP_W'(1);      // pick 0 is dup
                end else begin
                    src_d  = TOS_READ;
                    idx_d  = pick_n - SP_W'(1);
                    need_d = pick_far ? '1 : pick_n + SP_W'(1);   // saturate to force underflow
                end
            end
            OP_DROP, OP_EMIT: begin
                op_d   = SOP_POP;
                src_d  = TOS_READ;          // popped cell becomes tos
                need_d = SP_W'(1);
                emit_d = (opcode == OP_EMIT);
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                op_d   = SOP_POP;
                src_d  = TOS_ALU;
                need_d = SP_W'(2);
                case (opcode)
                    OP_ADD:  fn_d = ALU_ADD;
                    OP_SUB:  fn_d = ALU_SUB;
                    OP_AND:  fn_d = ALU_AND;
                    OP_OR:   fn_d = ALU_OR;
                    default: fn_d = ALU_XOR;
                endcase
            end
            default: begin
                op_d = SOP_NOP;             // nop and unused codes
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // control word, only meaningful with dec_valid
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            stack_op   <= op_d;
            alu_fn     <= fn_d;
            tos_src    <= src_d;
            read_index <= idx_d;
            dec_imm    <= imm;
            emit_req   <= emit_d;
            need_depth <= need_d;
            grows      <= grows_d;
        end
    end

endmodule : word_decode

`default_nettype wire

/* src/word_execute.sv */
/* word_execute: second pipeline stage
   TOS register, depth, ALU, underflow and overflow checks, stack memory */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module word_execute import forth_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      dec_valid,
    input  wire stack_op_e                 stack_op,
    input  wire alu_fn_e                   alu_fn,
    input  wire tos_src_e                  tos_src,
    input  wire logic [`FORTH_SP_W-1:0]    read_index,
    input  wire logic [`FORTH_DATA_W-1:0]  dec_imm,
    input  wire logic                      emit_req,
    input  wire logic [`FORTH_SP_W-1:0]    need_depth,
    input  wire logic                      grows,
    output logic                           ex_valid,
    output logic                           emit_fire,
    output logic      [`FORTH_DATA_W-1:0]  emit_value,
    output logic      [`FORTH_SP_W-1:0]    depth,
    output logic                           err_under,
    output logic                           err_over
);

    localparam int SP_W = `FORTH_SP_W;
    localparam logic [`FORTH_SP_W-1:0] CAPACITY = SP_W'(`FORTH_STACK_DEPTH + 1);

    logic [`FORTH_DATA_W-1:0] tos;
    logic                     tos_valid;    // depth above zero
    logic [`FORTH_SP_W-1:0]   fill;
    logic [`FORTH_DATA_W-1:0] rdata;        // second item or picked cell
    logic [`FORTH_DATA_W-1:0] alu_out;
    logic [`FORTH_DATA_W-1:0] tos_next;
    stack_op_e                mem_op;
    logic                     under;
    logic                     over;
    logic                     ok;
    logic                     empties;      // pop that leaves nothing

    assign depth   = fill + SP_W'(tos_valid);
    assign under   = dec_valid && (need_depth > depth);
    assign over    = dec_valid && grows && (depth == CAPACITY);
    assign ok      = dec_valid && !under && !over;
    assign empties = (stack_op == SOP_POP) && (fill == '0);

    // errored words leave the memory alone
    always_comb begin
        mem_op = SOP_NOP;
        if (ok) begin
            case (stack_op)
                SOP_PUSH: mem_op = tos_valid ? SOP_PUSH : SOP_NOP;   // nothing to spill when empty
                SOP_POP:  mem_op = empties ? SOP_NOP : SOP_POP;
                default:  mem_op = SOP_NOP;
            endcase
        end
    end

    always_comb begin
        case (alu_fn)
            ALU_ADD: alu_out = rdata + tos;
            ALU_SUB: alu_out = rdata - tos;     // second minus tos
            ALU_AND: alu_out = rdata & tos;
            ALU_OR:  alu_out = rdata | tos;
            ALU_XOR: alu_out = rdata ^ tos;
            default: alu_out = rdata;
        endcase
    end

    always_comb begin
        case (tos_src)
            TOS_IMM:  tos_next = dec_imm;
            TOS_READ: tos_next = rdata;
            TOS_ALU:  tos_next = alu_out;
            default:  tos_next = tos;
        endcase
    end

    data_stack u_stack (
        .clk   (clk),
        .reset (reset),
        .op    (mem_op),
        .wdata (tos),
        .index (read_index),
        .rdata (rdata),
        .fill  (fill)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            tos_valid <= 1'b0;
            ex_valid  <= 1'b0;
            emit_fire <= 1'b0;
            err_under <= 1'b0;
            err_over  <= 1'b0;
        end else begin
            ex_valid  <= dec_valid;
            emit_fire <= ok && emit_req;
            err_under <= under;             // one cycle pulses
            err_over  <= over;
            if (ok && grows) begin
                tos_valid <= 1'b1;
            end else if (ok && empties) begin
                tos_valid <= 1'b0;          // last item gone
            end
        end
    end

    always_ff @(posedge clk) begin
        emit_value <= tos;                  // old tos, qualified by emit_fire
        if (ok && !empties) begin
            tos <= tos_next;
        end
    end

endmodule : word_execute

`default_nettype wire

/* testbench/forth_core_chk.sv */
/* concurrent assertions on the stack core outputs
   bound into forth_core */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module forth_core_chk (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    emit_valid,
    input wire logic [`FORTH_SP_W-1:0]  depth,
    input wire logic                    underflow,
    input wire logic                    overflow
);

    localparam int CAP = `FORTH_STACK_DEPTH + 1;    // memory cells plus tos

    int fail_count = 0;                             // assertion failures so far

    a_depth_cap: assert property (@(posedge clk) disable iff (reset) depth <= CAP)
        else begin
            fail_count++;
            $error("depth %0d above capacity", depth);
        end

    // error flags only drop through reset
    a_under_sticky: assert property (@(posedge clk) $fell(underflow) |-> $past(reset))
        else begin
            fail_count++;
            $error("underflow cleared without reset");
        end

    a_over_sticky: assert property (@(posedge clk) $fell(overflow) |-> $past(reset))
        else begin
            fail_count++;
            $error("overflow cleared without reset");
        end

    // pipeline still empty for three cycles after release
    a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !emit_valid [*3])
        else begin
            fail_count++;
            $error("emit_valid right after reset");
        end

endmodule : forth_core_chk

bind forth_core forth_core_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .emit_valid (emit_valid),
    .depth      (depth),
    .underflow  (underflow),
    .overflow   (overflow)
);

`default_nettype wire

/* testbench/forth_core_tb.sv */
/* testbench for forth_core with a reference model of the stack rules,
   directed and random instruction streams and a comparing process */
`timescale 1ns/1ps
`default_nettype none
`include "forth_defines.svh"

module forth_core_tb import forth_pkg::*;;

    localparam int CAP = `FORTH_STACK_DEPTH + 1;      // memory plus tos

    typedef struct packed {
        logic [31:0]              due;                // cycle of the result
        logic                     emit;
        logic [`FORTH_DATA_W-1:0] data;
        logic [`FORTH_SP_W-1:0]   depth;
        logic                     under;
        logic                     over;
    } expect_t;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     instr_valid;
    opcode_e                  opcode;
    logic [`FORTH_DATA_W-1:0] imm;
    logic                     emit_valid;
    logic [`FORTH_DATA_W-1:0] emit_data;
    logic [`FORTH_SP_W-1:0]   depth;
    logic                     underflow;
    logic                     overflow;

    logic [`FORTH_DATA_W-1:0] m_stk [CAP];            // model stack with the bottom at 0
    int                       m_depth;
    logic                     m_under;
    logic                     m_over;
    expect_t                  pending [$];
    expect_t                  head;
    int                       cyc = 0;
    int                       seed = 31;
    int                       errors = 0;
    int                       checks = 0;
    int                       tests = 0;
    int                       failed_tests = 0;
    int                       mark;

    forth_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .imm         (imm),
        .emit_valid  (emit_valid),
        .emit_data   (emit_data),
        .depth       (depth),
        .underflow   (underflow),
        .overflow    (overflow)
    );

    always #50 clk = ~clk;                            // 100 ns period

    always @(posedge clk) cyc <= cyc + 1;

    // applies one instruction to the model and returns the expected outputs
    function automatic expect_t model_step(input opcode_e op, input logic [31:0] val);
        expect_t     e;
        int          need;
        logic        grow;
        logic        bad_u;
        logic        bad_o;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        e    = '0;
        grow = (op == OP_LIT) || (op == OP_DUP) || (op == OP_OVER) || (op == OP_PICK);
        case (op)
            OP_DUP, OP_DROP, OP_EMIT: need = 1;
            OP_OVER, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: need = 2;
            OP_PICK: need = (val >= CAP) ? CAP + 1 : int'(val) + 1;   // pick n takes n+1
            default: need = 0;
        endcase
        bad_u   = need > m_depth;
        bad_o   = grow && (m_depth == CAP);
        m_under = m_under | bad_u;
        m_over  = m_over | bad_o;
        if (!bad_u && !bad_o) begin
            case (op)
                OP_LIT, OP_DUP, OP_OVER, OP_PICK: begin
                    if (op == OP_LIT) x = val;
                    else if (op == OP_DUP) x = m_stk[m_depth-1];
                    else if (op == OP_OVER) x = m_stk[m_depth-2];
                    else x = m_stk[m_depth-1-int'(val)];
                    m_stk[m_depth] = x;
                    m_depth++;
                end
                OP_DROP: m_depth--;
                OP_EMIT: begin
                    e.emit = 1'b1;
                    e.data = m_stk[m_depth-1];
                    m_depth--;
                end
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    a = m_stk[m_depth-2];             // second item
                    b = m_stk[m_depth-1];             // top
                    case (op)
                        OP_ADD:  x = a + b;
                        OP_SUB:  x = a - b;
                        OP_AND:  x = a & b;
                        OP_OR:   x = a | b;
                        default: x = a ^ b;
                    endcase
                    m_stk[m_depth-2] = x;
                    m_depth--;
                end
                default: ;                            // nop
            endcase
        end
        e.depth = m_depth;
        e.under = m_under;
        e.over  = m_over;
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, want);
            errors++;
        end
    endtask

    // results land on the falling edge three cycles after their strobe
    always @(negedge clk) begin
        if (!reset) begin
            if (pending.size() != 0 && pending[0].due == cyc) begin
                head = pending.pop_front();
                compare_field("emit_valid", emit_valid, head.emit);
                if (head.emit) compare_field("emit_data", emit_data, head.data);
                compare_field("depth", depth, head.depth);
                compare_field("underflow", underflow, head.under);
                compare_field("overflow", overflow, head.over);
            end else begin
                compare_field("emit_valid", emit_valid, 1'b0);   // nothing due
            end
        end
    end

    task automatic issue(input opcode_e op, input logic [31:0] val);
        expect_t e;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        opcode      = op;
        imm         = val;
        e           = model_step(op, val);
        e.due       = cyc + `FORTH_LATENCY;
        pending.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle(1);
        while (pending.size() != 0 && n < 20) begin    // bounded wait for the pipe
            @(posedge clk);
            n++;
        end
        if (pending.size() != 0) begin
            $display("timeout: %0d results never came out of the core", pending.size());
            errors++;
            pending.delete();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset       = 1'b1;
        instr_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset   = 1'b0;
        m_depth = 0;
        m_under = 1'b0;
        m_over  = 1'b0;
    endtask

    task automatic begin_test();
        apply_reset();
        mark = errors;
    endtask

    task automatic end_test(input string name);
        drain();
        tests++;
        if (errors != mark) failed_tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
    endtask

    initial begin
        logic [31:0] ops [5];
        int          code;
        logic [31:0] val;
        reset       = 1'b1;
        instr_valid = 1'b0;
        opcode      = OP_NOP;
        imm         = '0;
        ops         = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

        begin_test();
        for (int i = 0; i < 4; i++) issue(OP_LIT, 32'h11 * (i + 1));
        repeat (4) issue(OP_EMIT, 0);                 // comes back reversed
        end_test("lifo emit");

        begin_test();
        foreach (ops[i]) begin
            issue(OP_LIT, 32'h0f0f_1234);
            issue(OP_LIT, 32'h00ff_8001);
            issue(opcode_e'(ops[i]), 0);
            issue(OP_EMIT, 0);
        end
        issue(OP_LIT, 3);
        issue(OP_LIT, 5);
        issue(OP_SUB, 0);                             // wraps to 0xfffffffe
        issue(OP_EMIT, 0);
        end_test("alu ops");

        begin_test();
        for (int i = 1; i <= 4; i++) issue(OP_LIT, i);
        issue(OP_PICK, 2);
        issue(OP_OVER, 0);
        issue(OP_DUP, 0);
        issue(OP_PICK, 0);
        repeat (8) issue(OP_EMIT, 0);
        end_test("stack copies");

        begin_test();
        issue(OP_EMIT, 0);
        issue(OP_ADD, 0);
        issue(OP_LIT, 7);
        issue(OP_ADD, 0);                             // one item only
        issue(OP_EMIT, 0);
        end_test("underflow");

        begin_test();
        for (int i = 0; i < CAP + 1; i++) issue(OP_LIT, 32'h100 + i);
        repeat (CAP) issue(OP_EMIT, 0);
        end_test("overflow");

        begin_test();
        for (int i = 0; i < 300; i++) begin
            code = $unsigned($random(seed)) % 16;
            if (code > 11) code = 1;                  // extra literals keep the stack fed
            val = $random(seed);
            if (code == 5) val = $unsigned(val) % 20; // pick index sometimes too deep
            issue(opcode_e'(code), val);
            if (($random(seed) & 7) == 0) idle(1 + $unsigned($random(seed)) % 3);
        end
        end_test("random stream");

        errors = errors + dut0.u_chk.fail_count;      // failed concurrent assertions
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : forth_core_tb

`default_nettype wire
